//--- hw/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath width
`define EXEC_DW 32

// Move to and from special registers
`define EXEC_OPC_SPECIAL 6'o45

// Processor ID field of the status word
`define EXEC_MSR_ID 20'h3A5C1

`endif

//--- hw/execPkg.sv
package execPkg;

   // Unit that produces the result
   typedef enum logic [2:0] {
      ADD   = 3'd0,
      LOGIC = 3'd1,
      SHIFT = 3'd2,
      MOVE  = 3'd3,
      BSF   = 3'd4,
      LOAD  = 3'd5,
      STORE = 3'd6
   } unitSel_e;

   // Immediate read as shift and extend control
   typedef struct packed {
      logic [4:0] unusedHi;
      logic [1:0] bsfMode;     // Barrel shift mode
      logic [1:0] unusedMid;
      logic [1:0] mode;        // One-bit shift or sign extend
      logic [2:0] unusedLo;
      logic       cmpUnsigned; // Unsigned compare adjust
      logic       halfSel;     // Extend from half, else byte
   } immShift_t;

   // Immediate read as special register control
   typedef struct packed {
      logic        unusedTop;
      logic        toSpecial;  // Move into special register
      logic [12:0] unusedMid;
      logic        msrSel;     // Status register selected
   } immSpecial_t;

   typedef union packed {
      immShift_t   sft;
      immSpecial_t spr;
   } immWord_u;

   typedef struct packed {
      logic c;   // Carry
      logic ie;  // Interrupt enable
      logic be;  // Buslock enable
   } msrFlags_t;

endpackage

//--- hw/operandIf.sv
`timescale 1ns/1ps
`include "exec_params.svh"

interface operandIf;
   import execPkg::*;

   logic                fire;  // Operation valid this cycle
   logic [`EXEC_DW-1:0] opA;
   logic [`EXEC_DW-1:0] opB;
   logic [5:0]          opc;
   immWord_u            imm;
   unitSel_e            unit;

   // Driven by the issue register
   modport source (output fire, opA, opB, opc, imm, unit);

   // Read by ALU and barrel shifter
   modport sink (input fire, opA, opB, opc, imm, unit);

endinterface

//--- hw/operandRoute.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module operandRoute (
   input  logic                gclk,
   input  logic                grst,
   input  logic                issue,
   input  logic                busy,
   input  execPkg::unitSel_e   unit,
   input  logic [5:0]          opc,
   input  logic [15:0]         imm,
   input  logic [1:0]          srcSel,
   input  logic [1:0]          tgtSel,
   input  logic [`EXEC_DW-1:0] regA,
   input  logic [`EXEC_DW-1:0] regB,
   input  logic [`EXEC_DW-1:0] result,
   operandIf.source            ops
);
   logic [`EXEC_DW-1:0] selA;
   logic [`EXEC_DW-1:0] selB;
   logic [`EXEC_DW-1:0] immExt;
   logic                accept;

   assign accept = issue & ~busy;                      // Held off while busy
   assign immExt = {{(`EXEC_DW-16){imm[15]}}, imm};   // Sign extended

   always_comb begin
      case (srcSel)
         2'd0:    selA = regA;
         2'd1:    selA = result;   // Forward last result
         default: selA = '0;
      endcase
      case (tgtSel)
         2'd0:    selB = regB;
         2'd1:    selB = result;   // Forward last result
         default: selB = immExt;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         ops.fire <= 1'b0;
      end else begin
         ops.fire <= accept;
      end
   end

   // Issue register
   always_ff @(posedge gclk) begin
      if (accept) begin
         ops.opA  <= selA;
         ops.opB  <= selB;
         ops.opc  <= opc;
         ops.imm  <= imm;
         ops.unit <= unit;
      end
   end

endmodule

//--- hw/arithLogicUnit.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module arithLogicUnit (
   operandIf.sink              ops,
   input  execPkg::msrFlags_t  flags,
   output logic [`EXEC_DW-1:0] aluValue,
   output logic                aluCarry,
   output logic                aluCarryWrite,
   output execPkg::msrFlags_t  aluFlagsNext,
   output logic [3:0]          laneSel
);
   import execPkg::*;

   logic                isSub;
   logic                useCarry;
   logic                cmpAdj;
   logic [`EXEC_DW-1:0] addA;
   logic                addCin;
   logic [`EXEC_DW-1:0] addSum;
   logic                addCout;
   logic [`EXEC_DW-1:0] addValue;
   logic                addWritesC;
   logic [`EXEC_DW-1:0] logicValue;
   logic [`EXEC_DW-1:0] shiftValue;
   logic                shiftCarry;
   logic                isSpecial;
   logic                mfs;
   logic                mts;
   logic [`EXEC_DW-1:0] statusWord;
   logic [`EXEC_DW-1:0] moveValue;

   assign isSub    = ~ops.opc[5] & ops.opc[0];
   assign useCarry = ~ops.opc[5] & ops.opc[1];       // Carry-in from C
   assign cmpAdj   = ~ops.opc[3] & ops.imm.sft.cmpUnsigned;
   assign addA     = isSub ? ~ops.opA : ops.opA;     // B - A as B + ~A + 1
   assign addCin   = useCarry ? flags.c : isSub;
   assign {addCout, addSum} = ops.opB + addA + addCin;
   assign addValue = {(cmpAdj ? ~addCout : addSum[`EXEC_DW-1]), addSum[`EXEC_DW-2:0]};
   assign addWritesC = ~ops.opc[5] & ~ops.opc[2];    // Keep forms leave C

   always_comb begin
      case (ops.opc[1:0])
         2'd0:    logicValue = ops.opA | ops.opB;
         2'd1:    logicValue = ops.opA & ops.opB;
         2'd2:    logicValue = ops.opA ^ ops.opB;
         default: logicValue = ops.opA & ~ops.opB;  // And-not
      endcase
   end

   always_comb begin
      shiftCarry = ops.opA[0];   // Bit shifted out
      case (ops.imm.sft.mode)
         2'd0: shiftValue = {ops.opA[`EXEC_DW-1], ops.opA[`EXEC_DW-1:1]};
         2'd1: shiftValue = {flags.c, ops.opA[`EXEC_DW-1:1]};   // Through carry
         2'd2: shiftValue = {1'b0, ops.opA[`EXEC_DW-1:1]};
         default: begin
            shiftCarry = flags.c;
            if (ops.imm.sft.halfSel)
               shiftValue = {{(`EXEC_DW-16){ops.opA[15]}}, ops.opA[15:0]};
            else
               shiftValue = {{(`EXEC_DW-8){ops.opA[7]}}, ops.opA[7:0]};
         end
      endcase
   end

   assign isSpecial  = (ops.opc == `EXEC_OPC_SPECIAL) && (ops.unit == MOVE);
   assign mfs        = isSpecial & ~ops.imm.spr.toSpecial & ops.imm.spr.msrSel;
   assign mts        = isSpecial & ops.imm.spr.toSpecial & ops.imm.spr.msrSel;
   assign statusWord = {flags.c, 3'b000, `EXEC_MSR_ID, 5'b00000, flags.c, flags.ie, flags.be};
   assign moveValue  = mfs ? statusWord : ops.opA;

   always_comb begin
      case (ops.unit)
         ADD:     aluValue = addValue;
         LOGIC:   aluValue = logicValue;
         SHIFT:   aluValue = shiftValue;
         MOVE:    aluValue = moveValue;
         default: aluValue = addSum;   // Load and store address
      endcase
   end

   assign aluCarry      = (ops.unit == SHIFT) ? shiftCarry : addCout;
   assign aluCarryWrite = ops.fire & (((ops.unit == ADD) & addWritesC) |
                          ((ops.unit == SHIFT) & (ops.imm.sft.mode != 2'd3)));
   assign aluFlagsNext  = mts ? msrFlags_t'(ops.opA[2:0]) : flags;   // C, IE, BE

   // Big-endian lanes
   always_comb begin
      case (ops.opc[1:0])
         2'd0:    laneSel = 4'b1000 >> addSum[1:0];
         2'd1:    laneSel = addSum[1] ? 4'b0011 : 4'b1100;
         default: laneSel = 4'b1111;
      endcase
   end

endmodule

//--- hw/barrelShifter.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module barrelShifter (
   input  logic                gclk,
   input  logic                grst,
   operandIf.sink              ops,
   output logic [`EXEC_DW-1:0] bsfValue,
   output logic                bsfValid
);
   import execPkg::*;

   logic [4:0]          amount;
   logic [`EXEC_DW-1:0] shifted;
   logic                take;

   assign amount = ops.opB[4:0];
   assign take   = ops.fire && (ops.unit == BSF);

   always_comb begin
      case (ops.imm.sft.bsfMode)
         2'd0:    shifted = ops.opA >> amount;
         2'd1:    shifted = $signed(ops.opA) >>> amount;   // Sign fill
         default: shifted = ops.opA << amount;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         bsfValid <= 1'b0;
      end else begin
         bsfValid <= take;
      end
   end

   always_ff @(posedge gclk) begin
      if (take) bsfValue <= shifted;
   end

endmodule

//--- hw/resultMerge.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module resultMerge (
   input  logic                gclk,
   input  logic                grst,
   input  execPkg::unitSel_e   unit,
   input  logic                fire,
   input  logic [`EXEC_DW-1:0] aluValue,
   input  logic                aluCarry,
   input  logic                aluCarryWrite,
   input  execPkg::msrFlags_t  aluFlagsNext,
   input  logic [3:0]          laneSel,
   input  logic [`EXEC_DW-1:0] bsfValue,
   input  logic                bsfValid,
   input  logic [`EXEC_DW-1:0] storeData,
   input  logic [`EXEC_DW-1:0] wbDatI,
   input  logic                wbAck,
   output logic [`EXEC_DW-1:0] result,
   output logic                resultValid,
   output logic                busy,
   output execPkg::msrFlags_t  flags,
   output logic                wbCyc,
   output logic                wbStb,
   output logic                wbWe,
   output logic [`EXEC_DW-3:0] wbAdr,
   output logic [3:0]          wbSel,
   output logic [`EXEC_DW-1:0] wbDatO
);
   import execPkg::*;

   typedef enum logic [1:0] {IDLE, WAIT_SHIFT, BUS} mergeState_e;

   mergeState_e state;
   msrFlags_t   flagsD;
   logic        multiCycle;
   logic        busStart;

   assign multiCycle = (unit == BSF) || (unit == LOAD) || (unit == STORE);
   assign busStart   = fire && (state == IDLE) && ((unit == LOAD) || (unit == STORE));
   assign busy       = (state != IDLE) | (fire & multiCycle);   // Holds issue back

   always_comb begin
      flagsD = aluFlagsNext;
      if (aluCarryWrite) flagsD.c = aluCarry;
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         state       <= IDLE;
         result      <= '0;
         resultValid <= 1'b0;
         flags       <= '0;
         wbCyc       <= 1'b0;
         wbStb       <= 1'b0;
         wbWe        <= 1'b0;
      end else begin
         resultValid <= 1'b0;   // Single-cycle pulse
         case (state)
            IDLE: begin
               if (fire) begin
                  case (unit)
                     BSF: state <= WAIT_SHIFT;
                     LOAD, STORE: begin
                        state <= BUS;
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe  <= (unit == STORE);
                     end
                     default: begin
                        result      <= aluValue;
                        resultValid <= 1'b1;
                        flags       <= flagsD;
                     end
                  endcase
               end
            end
            WAIT_SHIFT: begin
               if (bsfValid) begin
                  result      <= bsfValue;
                  resultValid <= 1'b1;
                  state       <= IDLE;
               end
            end
            default: begin
               if (wbAck) begin   // Cycle ends next clock
                  wbCyc <= 1'b0;
                  wbStb <= 1'b0;
                  wbWe  <= 1'b0;
                  state <= IDLE;
                  if (!wbWe) begin
                     result      <= wbDatI;
                     resultValid <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // Bus payload, held for the whole cycle
   always_ff @(posedge gclk) begin
      if (busStart) begin
         wbAdr  <= aluValue[`EXEC_DW-1:2];   // Adder sum
         wbSel  <= laneSel;
         wbDatO <= storeData;   // Sampled alongside fire
      end
   end

endmodule

//--- hw/execUnit.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execUnit (
   input  logic                gclk,
   input  logic                grst,
   input  logic                issue,
   input  execPkg::unitSel_e   unit,
   input  logic [5:0]          opc,
   input  logic [15:0]         imm,
   input  logic [1:0]          srcSel,
   input  logic [1:0]          tgtSel,
   input  logic [`EXEC_DW-1:0] regA,
   input  logic [`EXEC_DW-1:0] regB,
   input  logic [`EXEC_DW-1:0] storeData,
   input  logic [`EXEC_DW-1:0] wbDatI,
   input  logic                wbAck,
   output logic                busy,
   output logic [`EXEC_DW-1:0] result,
   output logic                resultValid,
   output logic                flagC,
   output logic                flagIE,
   output logic                flagBE,
   output logic                wbCyc,
   output logic                wbStb,
   output logic                wbWe,
   output logic [`EXEC_DW-3:0] wbAdr,
   output logic [3:0]          wbSel,
   output logic [`EXEC_DW-1:0] wbDatO
);
   import execPkg::*;

   msrFlags_t           flags;
   msrFlags_t           aluFlagsNext;
   logic [`EXEC_DW-1:0] aluValue;
   logic                aluCarry;
   logic                aluCarryWrite;
   logic [3:0]          laneSel;
   logic [`EXEC_DW-1:0] bsfValue;
   logic                bsfValid;

   operandIf ops ();   // Issue register to both units

   operandRoute route (
      .gclk, .grst, .issue, .busy, .unit, .opc, .imm, .srcSel, .tgtSel,
      .regA, .regB, .result, .ops(ops)
   );

   arithLogicUnit alu (
      .ops(ops), .flags, .aluValue, .aluCarry, .aluCarryWrite, .aluFlagsNext, .laneSel
   );

   barrelShifter bsf (.gclk, .grst, .ops(ops), .bsfValue, .bsfValid);

   resultMerge merge (
      .gclk, .grst, .unit(ops.unit), .fire(ops.fire), .aluValue, .aluCarry,
      .aluCarryWrite, .aluFlagsNext, .laneSel, .bsfValue, .bsfValid, .storeData,
      .wbDatI, .wbAck, .result, .resultValid, .busy, .flags, .wbCyc, .wbStb,
      .wbWe, .wbAdr, .wbSel, .wbDatO
   );

   assign flagC  = flags.c;
   assign flagIE = flags.ie;
   assign flagBE = flags.be;

endmodule

//--- verif/execUnit_assertions.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execUnit_assertions (
   input logic                gclk,
   input logic                grst,
   input logic                issue,
   input logic                busy,
   input execPkg::unitSel_e   unit,
   input logic [5:0]          opc,
   input logic [15:0]         imm,
   input logic [1:0]          srcSel,
   input logic [1:0]          tgtSel,
   input logic [`EXEC_DW-1:0] regA,
   input logic [`EXEC_DW-1:0] regB,
   input logic [`EXEC_DW-1:0] storeData,
   input logic [`EXEC_DW-1:0] result,
   input logic                resultValid,
   input logic                flagC,
   input logic                flagIE,
   input logic                flagBE,
   input logic                wbCyc,
   input logic                wbStb,
   input logic                wbWe,
   input logic [`EXEC_DW-3:0] wbAdr,
   input logic [3:0]          wbSel,
   input logic [`EXEC_DW-1:0] wbDatO,
   input logic [`EXEC_DW-1:0] wbDatI,
   input logic                wbAck
);
   import execPkg::*;

   int                  errCount = 0;   // Failed checks so far
   logic                accept;
   logic                fast;
   logic                mem;
   logic                sub;
   logic                cin;
   logic                cOut;
   logic [`EXEC_DW-1:0] a;
   logic [`EXEC_DW-1:0] b;
   logic [`EXEC_DW-1:0] sum;
   logic [`EXEC_DW-1:0] expVal;     // Expected result or address
   logic [2:0]          expFlags;   // C, IE, BE
   logic [3:0]          expSel;
   logic [`EXEC_DW-1:0] modelRes;     // Predicted result register
   logic [2:0]          modelFlags;   // Predicted C, IE, BE
   logic                pendFast;     // Fast op lands next edge
   logic [1:0]          pendBsf;      // Shift result two edges out
   logic [`EXEC_DW-1:0] pendVal;
   logic [2:0]          pendFlags;

   assign accept = issue & ~busy;
   assign fast   = (unit == ADD) || (unit == LOGIC) || (unit == SHIFT) || (unit == MOVE);
   assign mem    = (unit == LOAD) || (unit == STORE);

   // Model of the accepted issue
   always_comb begin
      a = (srcSel == 2'd0) ? regA : (srcSel == 2'd1) ? modelRes : '0;
      b = (tgtSel == 2'd0) ? regB : (tgtSel == 2'd1) ? modelRes : {{16{imm[15]}}, imm};
      sub = ~opc[5] & opc[0];                            // B minus A
      cin = (~opc[5] & opc[1]) ? modelFlags[2] : sub;    // Carry-in form
      {cOut, sum} = {1'b0, b} + {1'b0, sub ? ~a : a} + {32'd0, cin};
      expFlags = modelFlags;
      expVal = sum;
      expSel = 4'b1111;
      case (unit)
         ADD: begin
            if (imm[1] && !opc[3]) expVal[31] = ~cOut;   // Unsigned compare
            if (!opc[2]) expFlags[2] = cOut;
         end
         LOGIC: begin
            case (opc[1:0])
               2'd0:    expVal = a | b;
               2'd1:    expVal = a & b;
               2'd2:    expVal = a ^ b;
               default: expVal = a & ~b;
            endcase
         end
         SHIFT: begin
            case (imm[6:5])
               2'd0:    expVal = {a[31], a[31:1]};
               2'd1:    expVal = {modelFlags[2], a[31:1]};
               2'd2:    expVal = {1'b0, a[31:1]};
               default: expVal = imm[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
            endcase
            if (imm[6:5] != 2'd3) expFlags[2] = a[0];   // Shifted-out bit
         end
         MOVE: begin
            expVal = a;
            if (opc == `EXEC_OPC_SPECIAL && imm[0]) begin
               if (imm[14]) expFlags = a[2:0];
               else expVal = {modelFlags[2], 3'b000, `EXEC_MSR_ID, 5'b00000, modelFlags};
            end
         end
         BSF: begin
            case (imm[10:9])
               2'd0:    expVal = a >> b[4:0];
               2'd1:    expVal = $signed(a) >>> b[4:0];
               default: expVal = a << b[4:0];
            endcase
         end
         default: begin   // Big-endian lanes
            case (opc[1:0])
               2'd0:    expSel = {sum[1:0] == 2'd0, sum[1:0] == 2'd1,
                                  sum[1:0] == 2'd2, sum[1:0] == 2'd3};   // Address 0 is lane 3
               2'd1:    expSel = {{2{~sum[1]}}, {2{sum[1]}}};
               default: expSel = 4'b1111;
            endcase
         end
      endcase
   end

   // Track the result register and flags
   always_ff @(posedge gclk) begin
      if (grst) begin
         modelRes   <= '0;
         modelFlags <= '0;
         pendFast   <= 1'b0;
         pendBsf    <= '0;
      end else begin
         pendFast <= accept && fast;
         pendBsf  <= {pendBsf[0], accept && (unit == BSF)};
         if (accept) begin
            pendVal   <= expVal;
            pendFlags <= expFlags;
         end
         if (pendFast) begin
            modelRes   <= pendVal;
            modelFlags <= pendFlags;
         end
         if (pendBsf[1]) modelRes <= pendVal;
         if (wbCyc && wbAck && !wbWe) modelRes <= wbDatI;   // Load data
      end
   end

   assert property (@(posedge gclk) disable iff (grst)
      accept && fast |-> ##2 resultValid && result == $past(expVal, 2) &&
         {flagC, flagIE, flagBE} == $past(expFlags, 2))
      else begin
         errCount++;
         $error("Fail %0t: ALU result or flags wrong", $time);
      end

   assert property (@(posedge gclk) disable iff (grst)
      accept && unit == BSF |-> ##3 resultValid && result == $past(expVal, 3))
      else begin
         errCount++;
         $error("Fail %0t: barrel shift result wrong", $time);
      end

   // Result and flags hold their predicted values between updates
   assert property (@(posedge gclk) disable iff (grst)
      result == modelRes && {flagC, flagIE, flagBE} == modelFlags)
      else begin
         errCount++;
         $error("Fail %0t: result register or flags changed unexpectedly", $time);
      end

   assert property (@(posedge gclk) disable iff (grst)
      accept && !fast |=> busy)
      else begin
         errCount++;
         $error("Fail %0t: busy not raised for a multi-cycle op", $time);
      end

   // Bus cycle opens with the sum as address
   assert property (@(posedge gclk) disable iff (grst)
      accept && mem |-> ##2 wbCyc && wbStb && wbWe == ($past(unit, 2) == STORE) &&
         wbAdr == $past(expVal[31:2], 2) && wbSel == $past(expSel, 2) &&
         ($past(unit, 2) != STORE || wbDatO == $past(storeData, 2)))
      else begin
         errCount++;
         $error("Fail %0t: bus address, lanes, data or direction wrong", $time);
      end

   assert property (@(posedge gclk) disable iff (grst)
      wbCyc && !wbAck |=> wbCyc && wbStb)
      else begin
         errCount++;
         $error("Fail %0t: bus cycle dropped before ack", $time);
      end

   assert property (@(posedge gclk) disable iff (grst)
      wbCyc && wbAck && !wbWe |=> resultValid && result == $past(wbDatI))
      else begin
         errCount++;
         $error("Fail %0t: load result wrong", $time);
      end

endmodule

//--- verif/execUnit_tb.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execUnit_tb;
   import execPkg::*;

   logic                gclk;
   logic                grst;
   logic                issue;
   unitSel_e            unit;
   logic [5:0]          opc;
   logic [15:0]         imm;
   logic [1:0]          srcSel;
   logic [1:0]          tgtSel;
   logic [`EXEC_DW-1:0] regA;
   logic [`EXEC_DW-1:0] regB;
   logic [`EXEC_DW-1:0] storeData;
   logic [`EXEC_DW-1:0] wbDatI = '0;
   logic                wbAck = 1'b0;
   logic                busy;
   logic [`EXEC_DW-1:0] result;
   logic                resultValid;
   logic                flagC;
   logic                flagIE;
   logic                flagBE;
   logic                wbCyc;
   logic                wbStb;
   logic                wbWe;
   logic [`EXEC_DW-3:0] wbAdr;
   logic [3:0]          wbSel;
   logic [`EXEC_DW-1:0] wbDatO;
   logic [1:0]          ackDelay = 2'd0;   // Idle cycles left before ack

   execUnit dut (.*);

   bind execUnit execUnit_assertions chk (.*);

   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   // Memory model, ack after 0 to 3 cycles
   always @(posedge gclk) begin
      wbAck <= 1'b0;
      if (wbCyc && wbStb && !wbAck) begin
         if (ackDelay == 2'd0) begin
            wbAck    <= 1'b1;
            wbDatI   <= $urandom;
            ackDelay <= 2'($urandom % 4);
         end else begin
            ackDelay <= ackDelay - 2'd1;
         end
      end
   end

   // First failed check ends the run
   always @(negedge gclk) begin
      if (dut.chk.errCount != 0) begin
         $display("TESTS FAILED");
         $fatal(1, "A result check failed");
      end
   end

   // Issue one operation, then wait for it to finish
   task automatic runOp(input unitSel_e u);
      logic [5:0]  op;
      logic [15:0] im;
      int          waited;
      im = 16'($urandom);
      case (u)
         ADD:     op = {3'b000, 3'($urandom)};
         LOGIC:   op = {4'b1000, 2'($urandom)};
         SHIFT:   op = 6'b100100;
         MOVE: begin
            op    = `EXEC_OPC_SPECIAL;
            im[0] = 1'b1;   // Status register
         end
         BSF:     op = 6'b010001;
         LOAD:    op = {4'b1100, 2'($urandom % 3)};
         default: op = {4'b1101, 2'($urandom % 3)};
      endcase
      @(posedge gclk);
      issue     <= 1'b1;
      unit      <= u;
      opc       <= op;
      imm       <= im;
      srcSel    <= 2'($urandom);   // 1 forwards last result
      tgtSel    <= 2'($urandom);
      regA      <= $urandom;
      regB      <= $urandom;
      storeData <= $urandom;
      @(posedge gclk);
      issue <= 1'b0;
      repeat (2) @(negedge gclk);   // Fire has happened
      waited = 0;
      while (busy) begin
         @(negedge gclk);
         waited++;
         if (waited > 20) begin
            $display("Timeout at %0t: busy never fell after an issue", $time);
            $display("TESTS FAILED");
            $fatal(1, "Operation did not complete");
         end
      end
   endtask

   initial begin
      void'($urandom(1624));
      grst      = 1'b1;
      issue     = 1'b0;
      unit      = ADD;
      opc       = '0;
      imm       = '0;
      srcSel    = '0;
      tgtSel    = '0;
      regA      = '0;
      regB      = '0;
      storeData = '0;
      repeat (5) @(posedge gclk);
      grst <= 1'b0;
      for (int k = 0; k < 7; k++) runOp(unitSel_e'(k));   // Every unit once
      repeat (120) runOp(unitSel_e'($urandom % 7));
      repeat (3) @(negedge gclk);
      if (dut.chk.errCount == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("TESTS FAILED");
         $fatal(1, "Result checks failed");
      end
   end

endmodule

//--- files.f
+incdir+hw
hw/execPkg.sv
hw/operandIf.sv
hw/operandRoute.sv
hw/arithLogicUnit.sv
hw/barrelShifter.sv
hw/resultMerge.sv
hw/execUnit.sv
verif/execUnit_assertions.sv
verif/execUnit_tb.sv

//--- Makefile
.PHONY: run clean

run: obj_dir/VexecUnit_tb
	@out="$$(./obj_dir/VexecUnit_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

obj_dir/VexecUnit_tb: files.f $(wildcard hw/*.sv hw/*.svh verif/*.sv)
	verilator --binary --timing --assert -f files.f --top-module execUnit_tb -o VexecUnit_tb

clean:
	rm -rf obj_dir
